//--- Makefile
VERILATOR  := verilator
TOP        := tb_ip_apb_wrapper
FILELIST   := ip_apb_wrapper.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- apb4_archinfo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Identification word plus a byte-writable scratch register
// Writes to the ID register are ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "periph_settings.svh"

module apb4_archinfo (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  apb_pkg::paddr_t paddr_i,
  input  apb_pkg::data_t  pwdata_i,
  input  apb_pkg::strb_t  pstrb_i,
  output apb_pkg::data_t  prdata_o
);

  apb_pkg::data_t scratch_q;
  logic           scratch_wr;

  assign scratch_wr = psel_i && penable_i && pwrite_i && (paddr_i == `REG_ARCH_SCRATCH);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scratch_q <= '0;
    end else if (scratch_wr) begin
      for (int i = 0; i < 4; i++) begin
        if (pstrb_i[i]) begin
          scratch_q[8*i +: 8] <= pwdata_i[8*i +: 8];
        end
      end
    end
  end

  always_comb begin
    case (paddr_i)
      `REG_ARCH_ID:      prdata_o = `ARCH_ID_VALUE;
      `REG_ARCH_SCRATCH: prdata_o = scratch_q;
      default:           prdata_o = '0;
    endcase
  end

endmodule

//--- apb4_pwm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PWM timer with a wrap interrupt
// Counter runs 0..period-1 while enabled, held at zero otherwise
// Duty at or above period gives a constant high output
// STATUS bit 0 is write-one-to-clear; a wrap in the same cycle wins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "periph_settings.svh"

module apb4_pwm (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  apb_pkg::paddr_t paddr_i,
  input  apb_pkg::data_t  pwdata_i,
  input  apb_pkg::strb_t  pstrb_i,
  output apb_pkg::data_t  prdata_o,
  output logic            pwm_o,
  output logic            irq_o
);

  periph_pkg::pwm_cnt_t period_q;
  periph_pkg::pwm_cnt_t duty_q;
  periph_pkg::pwm_cnt_t cnt_q;
  logic                 en_q;
  logic                 mask_q;
  logic                 flag_q;
  logic                 pwm_q;
  logic                 wr_en;
  logic                 wrap;
  logic                 status_clr;

  assign wr_en      = psel_i && penable_i && pwrite_i;
  assign status_clr = wr_en && (paddr_i == `REG_PWM_STATUS) && pstrb_i[0] && pwdata_i[0];
  // A zero period wraps every cycle
  assign wrap       = en_q && ((period_q == '0) || (cnt_q >= period_q - 1'b1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q     <= 1'b0;
      mask_q   <= 1'b0;
      period_q <= '0;
      duty_q   <= '0;
    end else if (wr_en) begin
      for (int i = 0; i < 2; i++) begin
        if (pstrb_i[i] && paddr_i == `REG_PWM_PERIOD) begin
          period_q[8*i +: 8] <= pwdata_i[8*i +: 8];
        end
        if (pstrb_i[i] && paddr_i == `REG_PWM_DUTY) begin
          duty_q[8*i +: 8] <= pwdata_i[8*i +: 8];
        end
      end
      if (pstrb_i[0] && paddr_i == `REG_PWM_CTRL) begin
        en_q   <= pwdata_i[0];
        mask_q <= pwdata_i[1];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      pwm_q  <= 1'b0;
      flag_q <= 1'b0;
    end else begin
      cnt_q  <= (!en_q || wrap) ? '0 : cnt_q + 1'b1;
      pwm_q  <= en_q && (cnt_q < duty_q);
      if (wrap) begin
        flag_q <= 1'b1;
      end else if (status_clr) begin
        flag_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (paddr_i)
      `REG_PWM_CTRL:   prdata_o = {30'h0, mask_q, en_q};
      `REG_PWM_PERIOD: prdata_o = {16'h0, period_q};
      `REG_PWM_DUTY:   prdata_o = {16'h0, duty_q};
      `REG_PWM_STATUS: prdata_o = {31'h0, flag_q};
      default:         prdata_o = '0;
    endcase
  end

  assign pwm_o = pwm_q;
  assign irq_o = flag_q && mask_q;

endmodule

//--- apb4_rng.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Galois LFSR random source, one step per data read
// A write seeds it under byte strobes; a zero seed loads the default
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "periph_settings.svh"

module apb4_rng (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  apb_pkg::paddr_t paddr_i,
  input  apb_pkg::data_t  pwdata_i,
  input  apb_pkg::strb_t  pstrb_i,
  output apb_pkg::data_t  prdata_o
);

  periph_pkg::lfsr_t lfsr_q;
  periph_pkg::lfsr_t lfsr_step;
  periph_pkg::lfsr_t seed;
  logic              data_acc;

  assign data_acc = psel_i && penable_i && (paddr_i == `REG_RNG_DATA);

  // Shift right, fold the taps in when a one drops out
  assign lfsr_step = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? `RNG_POLY : 32'h0);

  always_comb begin
    seed = lfsr_q;
    for (int i = 0; i < 4; i++) begin
      if (pstrb_i[i]) begin
        seed[8*i +: 8] = pwdata_i[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q <= `RNG_DEFAULT_SEED;
    end else if (data_acc && pwrite_i) begin
      lfsr_q <= (seed == '0) ? `RNG_DEFAULT_SEED : seed;
    end else if (data_acc) begin
      lfsr_q <= lfsr_step;
    end
  end

  assign prdata_o = (paddr_i == `REG_RNG_DATA) ? lfsr_q : '0;

endmodule

//--- apb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus-side types shared by the bridge and the APB peripherals
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package apb_pkg;

  typedef logic [31:0] mem_addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [11:0] paddr_t;
  typedef logic [3:0]  slot_t;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    RESP
  } bridge_state_e;

endpackage

//--- ip_apb_wrapper.f
+incdir+.
apb_pkg.sv
periph_pkg.sv
mem2apb.sv
apb4_archinfo.sv
apb4_rng.sv
apb4_pwm.sv
ip_apb_wrapper.sv
ip_apb_wrapper_properties.sv
tb_ip_apb_wrapper.sv

//--- ip_apb_wrapper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral subsystem top: bridge, archinfo, RNG and PWM
// Only accesses inside the peripheral region may arrive here
// Upper address bits above the slot field are not checked
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ip_apb_wrapper (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               mem_valid_i,
  input  apb_pkg::mem_addr_t mem_addr_i,
  input  apb_pkg::data_t     mem_wdata_i,
  input  apb_pkg::strb_t     mem_wstrb_i,
  output logic               mem_ready_o,
  output apb_pkg::data_t     mem_rdata_o,
  output logic               pwm_o,
  output logic               irq_o
);

  // Shared APB request lines
  apb_pkg::paddr_t paddr;
  apb_pkg::data_t  pwdata;
  apb_pkg::strb_t  pstrb;
  logic            pwrite;
  logic            penable;

  // Per-peripheral select and read data
  logic            psel_archinfo;
  logic            psel_rng;
  logic            psel_pwm;
  apb_pkg::data_t  prdata_archinfo;
  apb_pkg::data_t  prdata_rng;
  apb_pkg::data_t  prdata_pwm;

  mem2apb u_mem2apb (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .mem_valid_i      (mem_valid_i),
    .mem_addr_i       (mem_addr_i),
    .mem_wdata_i      (mem_wdata_i),
    .mem_wstrb_i      (mem_wstrb_i),
    .mem_ready_o      (mem_ready_o),
    .mem_rdata_o      (mem_rdata_o),
    .paddr_o          (paddr),
    .pwrite_o         (pwrite),
    .penable_o        (penable),
    .pwdata_o         (pwdata),
    .pstrb_o          (pstrb),
    .psel_archinfo_o  (psel_archinfo),
    .psel_rng_o       (psel_rng),
    .psel_pwm_o       (psel_pwm),
    .prdata_archinfo_i(prdata_archinfo),
    .prdata_rng_i     (prdata_rng),
    .prdata_pwm_i     (prdata_pwm)
  );

  apb4_archinfo u_apb4_archinfo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .psel_i   (psel_archinfo),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .paddr_i  (paddr),
    .pwdata_i (pwdata),
    .pstrb_i  (pstrb),
    .prdata_o (prdata_archinfo)
  );

  apb4_rng u_apb4_rng (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .psel_i   (psel_rng),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .paddr_i  (paddr),
    .pwdata_i (pwdata),
    .pstrb_i  (pstrb),
    .prdata_o (prdata_rng)
  );

  // Only the PWM raises an interrupt
  apb4_pwm u_apb4_pwm (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .psel_i   (psel_pwm),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .paddr_i  (paddr),
    .pwdata_i (pwdata),
    .pstrb_i  (pstrb),
    .prdata_o (prdata_pwm),
    .pwm_o    (pwm_o),
    .irq_o    (irq_o)
  );

endmodule

//--- ip_apb_wrapper_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB and memory-side sequencing rules of the bridge
// Bound to every mem2apb instance, idle while in reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ip_apb_wrapper_properties (
  input logic clk_i,
  input logic rst_n_i,
  input logic mem_valid_i,
  input logic mem_ready_o,
  input logic penable_o,
  input logic psel_archinfo_o,
  input logic psel_rng_o,
  input logic psel_pwm_o
);

  int unsigned fail_count = 0;
  logic        any_sel;

  assign any_sel = psel_archinfo_o || psel_rng_o || psel_pwm_o;

  penable_has_sel : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) penable_o |-> any_sel
  ) else begin
    fail_count++;
    $error("penable_o high without any psel");
  end

  // Access phase always follows a setup phase
  setup_before_access : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) penable_o |-> $past(any_sel && !penable_o)
  ) else begin
    fail_count++;
    $error("penable_o not preceded by a setup phase");
  end

  ready_single_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) mem_ready_o |=> !mem_ready_o
  ) else begin
    fail_count++;
    $error("mem_ready_o high for two cycles");
  end

  ready_needs_valid : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $rose(mem_ready_o) |-> mem_valid_i
  ) else begin
    fail_count++;
    $error("mem_ready_o rose without mem_valid_i");
  end

endmodule

bind mem2apb ip_apb_wrapper_properties u_ip_apb_wrapper_properties (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .mem_valid_i    (mem_valid_i),
  .mem_ready_o    (mem_ready_o),
  .penable_o      (penable_o),
  .psel_archinfo_o(psel_archinfo_o),
  .psel_rng_o     (psel_rng_o),
  .psel_pwm_o     (psel_pwm_o)
);

//--- mem2apb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Native memory request to APB bridge, one transfer in flight
// Ready comes three edges after valid; the request must be held
// Peripherals are assumed zero-wait and error-free
// Unmapped slots read zero and drop writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "periph_settings.svh"

module mem2apb (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               mem_valid_i,
  input  apb_pkg::mem_addr_t mem_addr_i,
  input  apb_pkg::data_t     mem_wdata_i,
  input  apb_pkg::strb_t     mem_wstrb_i,
  output logic               mem_ready_o,
  output apb_pkg::data_t     mem_rdata_o,
  output apb_pkg::paddr_t    paddr_o,
  output logic               pwrite_o,
  output logic               penable_o,
  output apb_pkg::data_t     pwdata_o,
  output apb_pkg::strb_t     pstrb_o,
  output logic               psel_archinfo_o,
  output logic               psel_rng_o,
  output logic               psel_pwm_o,
  input  apb_pkg::data_t     prdata_archinfo_i,
  input  apb_pkg::data_t     prdata_rng_i,
  input  apb_pkg::data_t     prdata_pwm_i
);

  apb_pkg::bridge_state_e state_q;
  apb_pkg::bridge_state_e state_d;
  apb_pkg::slot_t         req_slot;
  apb_pkg::paddr_t        addr_q;
  apb_pkg::data_t         wdata_q;
  apb_pkg::strb_t         strb_q;
  apb_pkg::data_t         rdata_q;
  apb_pkg::data_t         rdata_mux;
  logic                   sel_arch_q;
  logic                   sel_rng_q;
  logic                   sel_pwm_q;
  logic                   xfer_phase;
  logic                   mapped;

  assign req_slot = mem_addr_i[15:12];

  always_comb begin
    state_d = state_q;
    case (state_q)
      apb_pkg::IDLE: begin
        if (mem_valid_i) begin
          state_d = apb_pkg::SETUP;
        end
      end
      apb_pkg::SETUP:  state_d = apb_pkg::ACCESS;
      apb_pkg::ACCESS: state_d = apb_pkg::RESP;
      default:         state_d = apb_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= apb_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture request and decode the slot once, at acceptance
  always_ff @(posedge clk_i) begin
    if (state_q == apb_pkg::IDLE && mem_valid_i) begin
      addr_q     <= mem_addr_i[11:0];
      wdata_q    <= mem_wdata_i;
      strb_q     <= mem_wstrb_i;
      sel_arch_q <= (req_slot == apb_pkg::slot_t'(`SLOT_ARCHINFO));
      sel_rng_q  <= (req_slot == apb_pkg::slot_t'(`SLOT_RNG));
      sel_pwm_q  <= (req_slot == apb_pkg::slot_t'(`SLOT_PWM));
    end
  end

  assign xfer_phase = (state_q == apb_pkg::SETUP) || (state_q == apb_pkg::ACCESS);
  assign mapped     = sel_arch_q || sel_rng_q || sel_pwm_q;

  assign psel_archinfo_o = xfer_phase && sel_arch_q;
  assign psel_rng_o      = xfer_phase && sel_rng_q;
  assign psel_pwm_o      = xfer_phase && sel_pwm_q;
  // No enable phase toward an unmapped slot
  assign penable_o       = (state_q == apb_pkg::ACCESS) && mapped;
  assign paddr_o         = addr_q;
  assign pwrite_o        = |strb_q;
  assign pwdata_o        = wdata_q;
  assign pstrb_o         = strb_q;

  always_comb begin
    rdata_mux = '0;
    if (sel_arch_q) begin
      rdata_mux = prdata_archinfo_i;
    end else if (sel_rng_q) begin
      rdata_mux = prdata_rng_i;
    end else if (sel_pwm_q) begin
      rdata_mux = prdata_pwm_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == apb_pkg::ACCESS) begin
      rdata_q <= rdata_mux;
    end
  end

  assign mem_ready_o = (state_q == apb_pkg::RESP);
  assign mem_rdata_o = rdata_q;

endmodule

//--- periph_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral-side types for the PWM timer and the RNG
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package periph_pkg;

  // Counter, period and duty share one width
  typedef logic [15:0] pwm_cnt_t;

  typedef logic [31:0] lfsr_t;

endpackage

//--- periph_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map and register constants of the peripheral subsystem
// Slot comes from CPU address bits 15:12, offset from bits 11:0
// RNG_DEFAULT_SEED must stay nonzero or the LFSR locks up
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

`define SLOT_ARCHINFO 0
`define SLOT_RNG 1
`define SLOT_PWM 2

`define REG_ARCH_ID 12'h000
`define REG_ARCH_SCRATCH 12'h004
`define REG_RNG_DATA 12'h000
`define REG_PWM_CTRL 12'h000
`define REG_PWM_PERIOD 12'h004
`define REG_PWM_DUTY 12'h008
`define REG_PWM_STATUS 12'h00C

`define ARCH_ID_VALUE 32'h5253_0102
// Taps for x^32 + x^22 + x^2 + x + 1, right-shifting form
`define RNG_POLY 32'h8020_0003
`define RNG_DEFAULT_SEED 32'h1D87_2B41

`endif

//--- tb_ip_apb_wrapper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the peripheral subsystem
// Ready is expected three rising edges after valid is driven
// The bound checker keeps a count of assertion failures
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "periph_settings.svh"

module tb_ip_apb_wrapper;

  localparam int CLK_PERIOD  = 20;
  // Cycle budget per test with up to six cycles for each bus access
  localparam int BUS_CYCLES  = 6;
  localparam int ARCH_BUDGET = BUS_CYCLES * (1 + 18);
  localparam int RNG_BUDGET  = BUS_CYCLES * 11;
  localparam int DUTY_BUDGET = BUS_CYCLES * 6 + 2 * (40 + 2);
  localparam int IRQ_BUDGET  = BUS_CYCLES * 9 + 12 + 3;
  localparam int SLOT_BUDGET = BUS_CYCLES * 10;
  localparam int WATCHDOG_NS = 2 * CLK_PERIOD *
    (8 + ARCH_BUDGET + RNG_BUDGET + DUTY_BUDGET + IRQ_BUDGET + SLOT_BUDGET);

  logic               clk_i;
  logic               rst_n_i;
  logic               mem_valid_i;
  apb_pkg::mem_addr_t mem_addr_i;
  apb_pkg::data_t     mem_wdata_i;
  apb_pkg::strb_t     mem_wstrb_i;
  logic               mem_ready_o;
  apb_pkg::data_t     mem_rdata_o;
  logic               pwm_o;
  logic               irq_o;

  integer               seed = 79;
  apb_pkg::data_t       scratch_m;
  periph_pkg::lfsr_t    rng_m;
  periph_pkg::pwm_cnt_t duty_m;

  ip_apb_wrapper u_ip_apb_wrapper (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .mem_valid_i(mem_valid_i),
    .mem_addr_i (mem_addr_i),
    .mem_wdata_i(mem_wdata_i),
    .mem_wstrb_i(mem_wstrb_i),
    .mem_ready_o(mem_ready_o),
    .mem_rdata_o(mem_rdata_o),
    .pwm_o      (pwm_o),
    .irq_o      (irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input apb_pkg::data_t exp,
                            input apb_pkg::data_t act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s expected 0x%08h, got 0x%08h",
                          $time, name, exp, act));
    end
  endtask

  task automatic check_cnt(input string name, input periph_pkg::pwm_cnt_t exp,
                           input periph_pkg::pwm_cnt_t act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s expected %0d, got %0d",
                          $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  function automatic apb_pkg::mem_addr_t reg_addr(input int slot, input apb_pkg::paddr_t offset);
    return {16'h0, apb_pkg::slot_t'(slot), offset};
  endfunction

  // One right shift with the taps folded in when a one drops out
  function automatic periph_pkg::lfsr_t galois_next(input periph_pkg::lfsr_t s);
    periph_pkg::lfsr_t n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ `RNG_POLY;
    end
    return n;
  endfunction

  task automatic bus_access(input apb_pkg::mem_addr_t addr, input apb_pkg::data_t wdata,
                            input apb_pkg::strb_t strb, output apb_pkg::data_t rdata);
    int   edges;
    logic seen;
    edges = 0;
    seen  = 1'b0;
    rdata = '0;
    @(posedge clk_i);
    mem_valid_i <= 1'b1;
    mem_addr_i  <= addr;
    mem_wdata_i <= wdata;
    mem_wstrb_i <= strb;
    while (!seen && edges < 8) begin
      @(posedge clk_i);
      edges++;
      @(negedge clk_i);
      if (mem_ready_o) begin
        seen  = 1'b1;
        rdata = mem_rdata_o;
      end
    end
    if (!seen) begin
      abort_run("The DUT gave no mem_ready_o within 8 clock edges");
    end
    check_data("mem_ready_o latency in edges", 32'd3, apb_pkg::data_t'(edges));
    @(posedge clk_i);
    mem_valid_i <= 1'b0;
    mem_wstrb_i <= '0;
  endtask

  task automatic bus_write(input apb_pkg::mem_addr_t addr, input apb_pkg::data_t data,
                           input apb_pkg::strb_t strb);
    apb_pkg::data_t unused;
    bus_access(addr, data, strb, unused);
  endtask

  task automatic bus_read(input apb_pkg::mem_addr_t addr, output apb_pkg::data_t data);
    bus_access(addr, 32'h0, 4'h0, data);
  endtask

  task automatic count_pwm_high(input periph_pkg::pwm_cnt_t cycles,
                                output periph_pkg::pwm_cnt_t hits);
    hits = '0;
    // Let a register update settle into the counter
    repeat (2) @(posedge clk_i);
    repeat (cycles) begin
      @(negedge clk_i);
      if (pwm_o) begin
        hits++;
      end
    end
  endtask

  task automatic reset_and_latency();
    apb_pkg::data_t rdata;
    check_bit("pwm_o after reset", 1'b0, pwm_o);
    check_bit("irq_o after reset", 1'b0, irq_o);
    check_bit("mem_ready_o after reset", 1'b0, mem_ready_o);
    bus_read(reg_addr(`SLOT_ARCHINFO, `REG_ARCH_ID), rdata);
    check_data("archinfo ID", `ARCH_ID_VALUE, rdata);
  endtask

  task automatic scratch_register();
    apb_pkg::data_t wdata;
    apb_pkg::data_t rdata;
    apb_pkg::strb_t strb;
    scratch_m = '0;
    repeat (8) begin
      wdata = $random(seed);
      strb  = apb_pkg::strb_t'($random(seed));
      if (strb == '0) begin
        strb = 4'hF;
      end
      bus_write(reg_addr(`SLOT_ARCHINFO, `REG_ARCH_SCRATCH), wdata, strb);
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
          scratch_m[8*i +: 8] = wdata[8*i +: 8];
        end
      end
      bus_read(reg_addr(`SLOT_ARCHINFO, `REG_ARCH_SCRATCH), rdata);
      check_data("archinfo SCRATCH", scratch_m, rdata);
    end
    bus_write(reg_addr(`SLOT_ARCHINFO, `REG_ARCH_ID), ~`ARCH_ID_VALUE, 4'hF);
    bus_read(reg_addr(`SLOT_ARCHINFO, `REG_ARCH_ID), rdata);
    check_data("archinfo ID after write", `ARCH_ID_VALUE, rdata);
  endtask

  task automatic rng_sequence();
    periph_pkg::lfsr_t seed_word;
    apb_pkg::data_t    rdata;
    seed_word = $random(seed);
    bus_write(reg_addr(`SLOT_RNG, `REG_RNG_DATA), seed_word, 4'hF);
    rng_m = (seed_word == '0) ? `RNG_DEFAULT_SEED : seed_word;
    repeat (8) begin
      bus_read(reg_addr(`SLOT_RNG, `REG_RNG_DATA), rdata);
      check_data("RNG data", rng_m, rdata);
      rng_m = galois_next(rng_m);
    end
    // A zero seed falls back to the default
    bus_write(reg_addr(`SLOT_RNG, `REG_RNG_DATA), 32'h0, 4'hF);
    bus_read(reg_addr(`SLOT_RNG, `REG_RNG_DATA), rdata);
    check_data("RNG data after zero seed", `RNG_DEFAULT_SEED, rdata);
    rng_m = galois_next(`RNG_DEFAULT_SEED);
  endtask

  task automatic pwm_duty_cycle();
    periph_pkg::pwm_cnt_t period;
    periph_pkg::pwm_cnt_t duty;
    periph_pkg::pwm_cnt_t hits;
    apb_pkg::data_t       rdata;
    period = periph_pkg::pwm_cnt_t'(4 + {$random(seed)} % 37);
    duty   = periph_pkg::pwm_cnt_t'({$random(seed)} % 32'(period));
    bus_write(reg_addr(`SLOT_PWM, `REG_PWM_PERIOD), {16'h0, period}, 4'h3);
    bus_write(reg_addr(`SLOT_PWM, `REG_PWM_DUTY), {16'h0, duty}, 4'h3);
    bus_read(reg_addr(`SLOT_PWM, `REG_PWM_PERIOD), rdata);
    check_cnt("PWM PERIOD", period, rdata[15:0]);
    bus_write(reg_addr(`SLOT_PWM, `REG_PWM_CTRL), 32'h1, 4'h1);
    count_pwm_high(period, hits);
    check_cnt("pwm_o high cycles", duty, hits);
    duty   = period + periph_pkg::pwm_cnt_t'({$random(seed)} % 8);
    duty_m = duty;
    bus_write(reg_addr(`SLOT_PWM, `REG_PWM_DUTY), {16'h0, duty}, 4'h3);
    count_pwm_high(period, hits);
    check_cnt("pwm_o high cycles at full duty", period, hits);
    bus_write(reg_addr(`SLOT_PWM, `REG_PWM_CTRL), 32'h0, 4'h1);
  endtask

  task automatic pwm_interrupt();
    apb_pkg::data_t rdata;
    bus_write(reg_addr(`SLOT_PWM, `REG_PWM_STATUS), 32'h1, 4'hF);
    bus_read(reg_addr(`SLOT_PWM, `REG_PWM_STATUS), rdata);
    check_bit("PWM STATUS flag after clear", 1'b0, rdata[0]);
    bus_write(reg_addr(`SLOT_PWM, `REG_PWM_PERIOD), 32'd8, 4'h3);
    bus_write(reg_addr(`SLOT_PWM, `REG_PWM_CTRL), 32'h1, 4'h1);
    repeat (12) @(posedge clk_i);
    bus_read(reg_addr(`SLOT_PWM, `REG_PWM_STATUS), rdata);
    check_bit("PWM STATUS flag after wrap", 1'b1, rdata[0]);
    @(negedge clk_i);
    check_bit("irq_o with mask clear", 1'b0, irq_o);
    bus_write(reg_addr(`SLOT_PWM, `REG_PWM_CTRL), 32'h3, 4'h1);
    @(negedge clk_i);
    check_bit("irq_o with mask set", 1'b1, irq_o);
    // Stop the timer so no new wrap sets the flag again
    bus_write(reg_addr(`SLOT_PWM, `REG_PWM_CTRL), 32'h2, 4'h1);
    bus_write(reg_addr(`SLOT_PWM, `REG_PWM_STATUS), 32'h1, 4'hF);
    @(negedge clk_i);
    check_bit("irq_o after STATUS clear", 1'b0, irq_o);
    bus_read(reg_addr(`SLOT_PWM, `REG_PWM_STATUS), rdata);
    check_bit("PWM STATUS flag after W1C", 1'b0, rdata[0]);
  endtask

  task automatic unmapped_slot();
    apb_pkg::data_t rdata;
    bus_read(reg_addr(7, 12'h000), rdata);
    check_data("slot 7 read data", 32'h0, rdata);
    for (int off = 0; off < 16; off += 4) begin
      bus_write(reg_addr(7, apb_pkg::paddr_t'(off)), $random(seed), 4'hF);
    end
    bus_read(reg_addr(`SLOT_ARCHINFO, `REG_ARCH_SCRATCH), rdata);
    check_data("archinfo SCRATCH after slot 7 writes", scratch_m, rdata);
    bus_read(reg_addr(`SLOT_PWM, `REG_PWM_PERIOD), rdata);
    check_cnt("PWM PERIOD after slot 7 writes", 16'd8, rdata[15:0]);
    bus_read(reg_addr(`SLOT_PWM, `REG_PWM_DUTY), rdata);
    check_cnt("PWM DUTY after slot 7 writes", duty_m, rdata[15:0]);
    bus_read(reg_addr(`SLOT_PWM, `REG_PWM_CTRL), rdata);
    check_data("PWM CTRL after slot 7 writes", 32'h2, rdata);
    bus_read(reg_addr(`SLOT_RNG, `REG_RNG_DATA), rdata);
    check_data("RNG data after slot 7 writes", rng_m, rdata);
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run("Watchdog timeout: the tests did not finish within their time budget");
  end

  initial begin
    rst_n_i     <= 1'b0;
    mem_valid_i <= 1'b0;
    mem_addr_i  <= '0;
    mem_wdata_i <= '0;
    mem_wstrb_i <= '0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    reset_and_latency();
    scratch_register();
    rng_sequence();
    pwm_duty_cycle();
    pwm_interrupt();
    unmapped_slot();
    if (u_ip_apb_wrapper.u_mem2apb.u_ip_apb_wrapper_properties.fail_count == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      abort_run("Bound assertions on the bridge reported failures");
    end
  end

endmodule
